// ==== axil_slice_top.f ====
design/axil_pkg.sv
design/axil_if.sv
design/flow_reg_both.sv
design/axil_timing_slice.sv
design/axil_reg_target.sv
design/axil_slice_top.sv
test/axil_slice_tb.sv

// ==== test/axil_slice_tb.sv ====
/* Table-driven testbench for axil_slice_top. It checks every B and R against a
   reference register model, with random bready/rready stalls in the last part. */
`timescale 1ns/1ns

module axil_slice_tb
  import axil_pkg::*;
();

  typedef enum logic {OP_WRITE, OP_READ} op_e;

  typedef struct packed {
    op_e                   op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    int                    skew;
  } row_t;

  logic clk;
  logic rst_n;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic wvalid;
  logic wready;
  axil_resp_e bresp;
  logic bvalid;
  logic bready;
  logic [ADDR_WIDTH-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [DATA_WIDTH-1:0] rdata;
  axil_resp_e rresp;
  logic rvalid;
  logic rready;

  row_t rows[$];
  int stall_from;
  int cycle_limit;
  int cycle_count;
  logic stall_en;
  logic [31:0] lfsr_state;
  logic [DATA_WIDTH-1:0] ref_regs [NUM_REGS];

  axil_slice_top u_axil_slice_top (.*);

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s actual %h expected %h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // Response ready stalls at random once stall_en is set
  always @(posedge clk) begin
    if (stall_en) begin
      lfsr_state = lfsr_next(lfsr_state);
      bready <= lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
      rready <= lfsr_state[0];
    end else begin
      bready <= 1'b1;
      rready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_count);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic add_row(input op_e op, input logic [ADDR_WIDTH-1:0] addr,
                         input logic [DATA_WIDTH-1:0] data,
                         input logic [STRB_WIDTH-1:0] strb, input int skew);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.strb = strb;
    r.skew = skew;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Contents after reset
    for (int i = 0; i < 16; i++) add_row(OP_READ, 12'(i * 4), '0, '0, 0);
    // Full strobes
    add_row(OP_WRITE, 12'h000, 32'hdead_beef, 4'hf, 0);
    add_row(OP_WRITE, 12'h004, 32'h0123_4567, 4'hf, 0);
    add_row(OP_WRITE, 12'h020, 32'ha5a5_5a5a, 4'hf, 0);
    add_row(OP_WRITE, 12'h03c, 32'hcafe_f00d, 4'hf, 0);
    add_row(OP_READ, 12'h000, '0, '0, 0);
    add_row(OP_READ, 12'h004, '0, '0, 0);
    add_row(OP_READ, 12'h020, '0, '0, 0);
    add_row(OP_READ, 12'h03c, '0, '0, 0);
    // Partial strobes with some unaligned addresses
    add_row(OP_WRITE, 12'h004, 32'h89ab_cdef, 4'b0001, 0);
    add_row(OP_WRITE, 12'h020, 32'h1122_3344, 4'b1010, 0);
    add_row(OP_WRITE, 12'h03f, 32'h7700_0000, 4'b1000, 0);
    add_row(OP_WRITE, 12'h008, 32'hffff_ffff, 4'b0110, 0);
    add_row(OP_READ, 12'h004, '0, '0, 0);
    add_row(OP_READ, 12'h020, '0, '0, 0);
    add_row(OP_READ, 12'h03c, '0, '0, 0);
    add_row(OP_READ, 12'h00a, '0, '0, 0);
    // Outside the window and then a pass over every register
    add_row(OP_WRITE, 12'h040, 32'h5555_5555, 4'hf, 0);
    add_row(OP_WRITE, 12'hffc, 32'h6666_6666, 4'hf, 1);
    add_row(OP_READ, 12'h040, '0, '0, 0);
    add_row(OP_READ, 12'h800, '0, '0, 0);
    for (int i = 0; i < 16; i++) add_row(OP_READ, 12'(i * 4), '0, '0, 0);
    // AW before W, W before AW and both in the same cycle
    add_row(OP_WRITE, 12'h010, 32'h1010_1010, 4'hf, 1);
    add_row(OP_WRITE, 12'h014, 32'h1414_1414, 4'hf, -1);
    add_row(OP_WRITE, 12'h018, 32'h1818_1818, 4'hf, 0);
    add_row(OP_READ, 12'h010, '0, '0, 0);
    add_row(OP_READ, 12'h014, '0, '0, 0);
    add_row(OP_READ, 12'h018, '0, '0, 0);
    // Everything below runs with random response stalls
    stall_from = rows.size();
    for (int i = 0; i < 16; i++) begin
      add_row(OP_WRITE, 12'(i * 4), 32'(32'h9e37_79b9 * (i + 1)), 4'(i), (i % 3) - 1);
    end
    for (int i = 0; i < 16; i++) add_row(OP_READ, 12'(i * 4), '0, '0, 0);
    add_row(OP_WRITE, 12'h044, 32'h0bad_0bad, 4'hf, -1);
    add_row(OP_READ, 12'h07c, '0, '0, 0);
  endtask

  // Reference model updates ref_regs and gives the expected response
  task automatic predict(input row_t r, output logic [DATA_WIDTH-1:0] exp_data,
                         output axil_resp_e exp_resp);
    logic [DATA_WIDTH-1:0] mask;
    int idx;
    idx = r.addr[5:2];
    mask = {{8{r.strb[3]}}, {8{r.strb[2]}}, {8{r.strb[1]}}, {8{r.strb[0]}}};
    exp_data = '0;
    if (r.addr >= 12'h040) begin
      exp_resp = RESP_SLVERR;
    end else begin
      exp_resp = RESP_OKAY;
      if (r.op == OP_WRITE) ref_regs[idx] = (ref_regs[idx] & ~mask) | (r.data & mask);
      else exp_data = ref_regs[idx];
    end
  endtask

  task automatic run_row(input row_t r);
    int cyc;
    int aw_delay;
    int w_delay;
    bit aw_on;
    bit w_on;
    bit done;
    bit held;
    logic [DATA_WIDTH-1:0] exp_data;
    axil_resp_e exp_resp;
    logic [DATA_WIDTH-1:0] held_data;
    axil_resp_e held_resp;
    cyc = 0;
    aw_on = 0;
    w_on = 0;
    done = 0;
    held = 0;
    aw_delay = (r.skew < 0) ? 1 : 0;
    w_delay = (r.skew > 0) ? 1 : 0;
    predict(r, exp_data, exp_resp);
    while (!done) begin
      @(posedge clk);
      // A response left over from the previous row would show up here
      if (cyc == 0 || r.op == OP_READ) check_value("bvalid", bvalid, 1'b0);
      if (cyc == 0 || r.op == OP_WRITE) check_value("rvalid", rvalid, 1'b0);
      if (awvalid && awready) awvalid <= 1'b0;
      if (wvalid && wready) wvalid <= 1'b0;
      if (arvalid && arready) arvalid <= 1'b0;
      if (r.op == OP_WRITE) begin
        if (!aw_on && cyc >= aw_delay) begin
          awaddr  <= r.addr;
          awvalid <= 1'b1;
          aw_on = 1;
        end
        if (!w_on && cyc >= w_delay) begin
          wdata  <= r.data;
          wstrb  <= r.strb;
          wvalid <= 1'b1;
          w_on = 1;
        end
        // A stalled B must stay up with the same payload
        if (held) begin
          check_value("bvalid", bvalid, 1'b1);
          check_value("bresp", bresp, held_resp);
        end
        if (bvalid && bready) begin
          check_value("bresp", bresp, exp_resp);
          done = 1;
        end else if (bvalid) begin
          held = 1;
          held_resp = bresp;
        end
      end else begin
        if (cyc == 0) begin
          araddr  <= r.addr;
          arvalid <= 1'b1;
        end
        if (held) begin
          check_value("rvalid", rvalid, 1'b1);
          check_value("rdata", rdata, held_data);
          check_value("rresp", rresp, held_resp);
        end
        if (rvalid && rready) begin
          check_value("rdata", rdata, exp_data);
          check_value("rresp", rresp, exp_resp);
          done = 1;
        end else if (rvalid) begin
          held = 1;
          held_data = rdata;
          held_resp = rresp;
        end
      end
      cyc++;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    stall_en = 1'b0;
    cycle_count = 0;
    lfsr_state = 32'h6341_0c67;
    for (int i = 0; i < NUM_REGS; i++) ref_regs[i] = '0;
    build_table();
    cycle_limit = rows.size() * 64 + 16;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("bvalid", bvalid, 1'b0);
    check_value("rvalid", rvalid, 1'b0);
    check_value("awready", awready, 1'b1);
    check_value("wready", wready, 1'b1);
    check_value("arready", arready, 1'b1);
    for (int i = 0; i < rows.size(); i++) begin
      stall_en <= (i >= stall_from);
      run_row(rows[i]);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule : axil_slice_tb

// ==== design/axil_slice_top.sv ====
/* Top level with plain AXI4-Lite target ports. The host bus passes through the
   timing slice and then reaches the register file target. */
`timescale 1ns/1ns

module axil_slice_top
  import axil_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Write address
  input  logic [ADDR_WIDTH-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,

  // Write data
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic [STRB_WIDTH-1:0] wstrb,
  input  logic                  wvalid,
  output logic                  wready,

  // Write response
  output axil_resp_e            bresp,
  output logic                  bvalid,
  input  logic                  bready,

  // Read address
  input  logic [ADDR_WIDTH-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,

  // Read data
  output logic [DATA_WIDTH-1:0] rdata,
  output axil_resp_e            rresp,
  output logic                  rvalid,
  input  logic                  rready
);

  axil_if host_bus ();
  axil_if reg_bus ();

  // Host side requests
  assign host_bus.awaddr  = awaddr;
  assign host_bus.awvalid = awvalid;
  assign host_bus.wdata   = wdata;
  assign host_bus.wstrb   = wstrb;
  assign host_bus.wvalid  = wvalid;
  assign host_bus.bready  = bready;
  assign host_bus.araddr  = araddr;
  assign host_bus.arvalid = arvalid;
  assign host_bus.rready  = rready;

  // Host side responses
  assign awready = host_bus.awready;
  assign wready  = host_bus.wready;
  assign bresp   = host_bus.bresp;
  assign bvalid  = host_bus.bvalid;
  assign arready = host_bus.arready;
  assign rdata   = host_bus.rdata;
  assign rresp   = host_bus.rresp;
  assign rvalid  = host_bus.rvalid;

  axil_timing_slice u_slice (
    .clk,
    .rst_n,
    .tgt (host_bus.target),
    .init(reg_bus.initiator)
  );

  axil_reg_target u_regs (
    .clk,
    .rst_n,
    .bus(reg_bus.target)
  );

endmodule : axil_slice_top

// ==== design/axil_reg_target.sv ====
/* AXI4-Lite target holding sixteen 32-bit registers with byte-strobe writes.
   Accesses at or above the register window answer SLVERR and change nothing. */
`timescale 1ns/1ns

module axil_reg_target
  import axil_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  axil_if.target bus
);

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  // Write side
  wr_state_e             wr_state;
  logic                  aw_held;
  logic                  w_held;
  logic [ADDR_WIDTH-1:0] aw_addr_q;
  logic [DATA_WIDTH-1:0] wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;
  axil_resp_e            bresp_q;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  wr_go;

  // Read side
  rd_state_e             rd_state;
  logic [DATA_WIDTH-1:0] rdata_q;
  axil_resp_e            rresp_q;
  logic                  ar_fire;

  function automatic logic in_window(input logic [ADDR_WIDTH-1:0] addr);
    return addr < ADDR_WIDTH'(NUM_REGS * 4);
  endfunction

  // Word index, low two address bits dropped
  function automatic logic [REG_IDX_WIDTH-1:0] reg_index(input logic [ADDR_WIDTH-1:0] addr);
    return addr[REG_IDX_WIDTH+1:2];
  endfunction

  function automatic logic [DATA_WIDTH-1:0] merge_bytes(
    input logic [DATA_WIDTH-1:0] old_word,
    input logic [DATA_WIDTH-1:0] new_word,
    input logic [STRB_WIDTH-1:0] strb
  );
    logic [DATA_WIDTH-1:0] result;
    result = old_word;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // Each address channel is open only until its own beat is held
  assign bus.awready = (wr_state == WR_COLLECT) && !aw_held;
  assign bus.wready  = (wr_state == WR_COLLECT) && !w_held;
  assign bus.bvalid  = (wr_state == WR_RESP);
  assign bus.bresp   = bresp_q;

  assign aw_fire = bus.awvalid && bus.awready;
  assign w_fire  = bus.wvalid && bus.wready;
  assign wr_go   = (wr_state == WR_COLLECT) && aw_held && w_held;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_state <= WR_COLLECT;
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (wr_state)
        WR_COLLECT: begin
          if (aw_fire) aw_held <= 1'b1;
          if (w_fire) w_held <= 1'b1;
          if (wr_go) begin
            if (in_window(aw_addr_q)) begin
              regs[reg_index(aw_addr_q)] <=
                merge_bytes(regs[reg_index(aw_addr_q)], wdata_q, wstrb_q);
            end
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            wr_state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (bus.bready) wr_state <= WR_COLLECT;
        end
        default: wr_state <= WR_COLLECT;
      endcase
    end
  end

  // Write holding registers and response code
  always_ff @(posedge clk) begin
    if (aw_fire) aw_addr_q <= bus.awaddr;
    if (w_fire) begin
      wdata_q <= bus.wdata;
      wstrb_q <= bus.wstrb;
    end
    if (wr_go) bresp_q <= in_window(aw_addr_q) ? RESP_OKAY : RESP_SLVERR;
  end

  assign bus.arready = (rd_state == RD_IDLE);
  assign bus.rvalid  = (rd_state == RD_RESP);
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = rresp_q;

  assign ar_fire = bus.arvalid && bus.arready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (ar_fire) rd_state <= RD_RESP;
        RD_RESP: if (bus.rready) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // Read data is zero outside the window
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      if (in_window(bus.araddr)) begin
        rdata_q <= regs[reg_index(bus.araddr)];
        rresp_q <= RESP_OKAY;
      end else begin
        rdata_q <= '0;
        rresp_q <= RESP_SLVERR;
      end
    end
  end

endmodule : axil_reg_target

// ==== design/axil_timing_slice.sv ====
/* Registers all five AXI4-Lite channels between a host-facing target port and
   a downstream initiator port. Each channel adds one cycle in its own direction. */
`timescale 1ns/1ns

module axil_timing_slice
  import axil_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  axil_if.target     tgt,
  axil_if.initiator  init
);

  // Reverse channels come out as flat vectors and are split afterwards
  logic [RESP_WIDTH-1:0]            b_pop_data;
  logic [DATA_WIDTH+RESP_WIDTH-1:0] r_pop_data;

  // Write address
  flow_reg_both #(.width(ADDR_WIDTH)) aw_slice (
    .clk,
    .rst_n,
    .push_valid(tgt.awvalid),
    .push_ready(tgt.awready),
    .push_data (tgt.awaddr),
    .pop_valid (init.awvalid),
    .pop_ready (init.awready),
    .pop_data  (init.awaddr)
  );

  // Write data with strobes
  flow_reg_both #(.width(DATA_WIDTH + STRB_WIDTH)) w_slice (
    .clk,
    .rst_n,
    .push_valid(tgt.wvalid),
    .push_ready(tgt.wready),
    .push_data ({tgt.wdata, tgt.wstrb}),
    .pop_valid (init.wvalid),
    .pop_ready (init.wready),
    .pop_data  ({init.wdata, init.wstrb})
  );

  // Write response, runs back toward the host
  flow_reg_both #(.width(RESP_WIDTH)) b_slice (
    .clk,
    .rst_n,
    .push_valid(init.bvalid),
    .push_ready(init.bready),
    .push_data (init.bresp),
    .pop_valid (tgt.bvalid),
    .pop_ready (tgt.bready),
    .pop_data  (b_pop_data)
  );

  assign tgt.bresp = axil_resp_e'(b_pop_data);

  // Read address
  flow_reg_both #(.width(ADDR_WIDTH)) ar_slice (
    .clk,
    .rst_n,
    .push_valid(tgt.arvalid),
    .push_ready(tgt.arready),
    .push_data (tgt.araddr),
    .pop_valid (init.arvalid),
    .pop_ready (init.arready),
    .pop_data  (init.araddr)
  );

  // Read data and response
  flow_reg_both #(.width(DATA_WIDTH + RESP_WIDTH)) r_slice (
    .clk,
    .rst_n,
    .push_valid(init.rvalid),
    .push_ready(init.rready),
    .push_data ({init.rdata, init.rresp}),
    .pop_valid (tgt.rvalid),
    .pop_ready (tgt.rready),
    .pop_data  (r_pop_data)
  );

  assign tgt.rdata = r_pop_data[DATA_WIDTH+RESP_WIDTH-1:RESP_WIDTH];
  assign tgt.rresp = axil_resp_e'(r_pop_data[RESP_WIDTH-1:0]);

endmodule : axil_timing_slice

// ==== design/flow_reg_both.sv ====
/* Full timing slice for one valid/ready channel: registered forward path plus
   a one-entry skid buffer so push_ready also comes straight from a flop. */
`timescale 1ns/1ns

module flow_reg_both #(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             rst_n,

  // Upstream side
  input  logic             push_valid,
  output logic             push_ready,
  input  logic [width-1:0] push_data,

  // Downstream side
  output logic             pop_valid,
  input  logic             pop_ready,
  output logic [width-1:0] pop_data
);

  logic             skid_valid;
  logic [width-1:0] skid_data;

  logic push_fire;
  logic main_free;
  logic pop_valid_next;
  logic skid_valid_next;

  assign push_fire = push_valid && push_ready;

  // Output register can take a new beat this cycle
  assign main_free = !pop_valid || pop_ready;

  // Skid entry always drains first, push_ready is low while it is full
  always_comb begin
    if (main_free) begin
      pop_valid_next  = skid_valid || push_fire;
      skid_valid_next = 1'b0;
    end else begin
      pop_valid_next  = 1'b1;
      skid_valid_next = skid_valid || push_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pop_valid  <= 1'b0;
      skid_valid <= 1'b0;
      push_ready <= 1'b1;
    end else begin
      pop_valid  <= pop_valid_next;
      skid_valid <= skid_valid_next;
      push_ready <= !skid_valid_next;
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        pop_data <= skid_data;
      end else if (push_fire) begin
        pop_data <= push_data;
      end
    end else if (push_fire) begin
      // Output is stalled, park the incoming beat
      skid_data <= push_data;
    end
  end

endmodule : flow_reg_both

// ==== design/axil_if.sv ====
/* AXI4-Lite bundle of all five channels, used between the slice and the target.
   The initiator modport drives requests, the target modport drives responses. */
`timescale 1ns/1ns

interface axil_if
  import axil_pkg::*;
();

  // Write address channel
  logic [ADDR_WIDTH-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;

  // Write data channel
  logic [DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;

  // Write response channel
  axil_resp_e            bresp;
  logic                  bvalid;
  logic                  bready;

  // Read address channel
  logic [ADDR_WIDTH-1:0] araddr;
  logic                  arvalid;
  logic                  arready;

  // Read data channel
  logic [DATA_WIDTH-1:0] rdata;
  axil_resp_e            rresp;
  logic                  rvalid;
  logic                  rready;

  modport initiator (
    output awaddr, awvalid,
    input  awready,
    output wdata, wstrb, wvalid,
    input  wready,
    input  bresp, bvalid,
    output bready,
    output araddr, arvalid,
    input  arready,
    input  rdata, rresp, rvalid,
    output rready
  );

  modport target (
    input  awaddr, awvalid,
    output awready,
    input  wdata, wstrb, wvalid,
    output wready,
    output bresp, bvalid,
    input  bready,
    input  araddr, arvalid,
    output arready,
    output rdata, rresp, rvalid,
    input  rready
  );

endinterface : axil_if

// ==== design/axil_pkg.sv ====
/* Shared widths, register count and enums for the AXI4-Lite timing slice project.
   Imported by the interface, the slice, the register target and the top level. */
package axil_pkg;

  // Bus widths
  localparam int ADDR_WIDTH = 12;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int RESP_WIDTH = 2;

  // Register file geometry
  localparam int NUM_REGS      = 16;
  localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);

  // AXI response codes, only the two the target can return
  typedef enum logic [RESP_WIDTH-1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // Write side of the target
  // WR_COLLECT gathers AW and W, WR_RESP holds B until accepted
  typedef enum logic {
    WR_COLLECT,
    WR_RESP
  } wr_state_e;

  // Read side of the target
  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

endpackage : axil_pkg
